//--- hw/pea_pkg.sv
// Array geometry is fixed here and ROW_SEL_W must be wide enough to address PEA_ROWS
package pea_pkg;

  ////////////////////////////////////////////////////////////
  // Array geometry
  ////////////////////////////////////////////////////////////
  localparam int PEA_ROWS    = 4;
  localparam int PEA_COLS    = 4;
  // Only the top rows see the input stream
  localparam int STREAM_ROWS = 2;
  localparam int DATA_W      = 32;
  localparam int CONST_W     = 8;
  localparam int ROW_SEL_W   = 2;

  ////////////////////////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////////////////////////
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [CONST_W-1:0]   pe_const_t;
  typedef logic [ROW_SEL_W-1:0] row_sel_t;

  // Operand source of a PE
  typedef enum logic [2:0] {
    SRC_OFF    = 3'd0,
    SRC_STREAM = 3'd1,
    SRC_CONST  = 3'd2,
    SRC_SELF   = 3'd3,
    SRC_NORTH  = 3'd4,
    SRC_SOUTH  = 3'd5,
    SRC_WEST   = 3'd6,
    SRC_EAST   = 3'd7
  } pe_src_e;

  // 3'd7 is not assigned
  typedef enum logic [2:0] {
    OP_ADD    = 3'd0,
    OP_SUB    = 3'd1,
    OP_MUL    = 3'd2,
    OP_AND    = 3'd3,
    OP_OR     = 3'd4,
    OP_XOR    = 3'd5,
    OP_PASS_A = 3'd6
  } pe_op_e;

  // Static configuration of one PE
  typedef struct packed {
    pe_src_e src_a;
    pe_src_e src_b;
    pe_op_e  op;
  } pe_cfg_t;

  // One beat of a valid-only stream
  typedef struct packed {
    logic  valid;
    data_t data;
  } stream_t;

  // Tie-off for array edges and rows without the stream
  localparam stream_t EDGE_BEAT = '{valid: 1'b1, data: '0};

endpackage

//--- hw/pe_alu.sv
// Purely combinational. Arithmetic wraps modulo 2^32 and the unassigned op code yields zero
`timescale 1ns/1ns

module pe_alu
  import pea_pkg::*;
(
  input  pe_op_e op_i,
  input  data_t  a_i,
  input  data_t  b_i,
  output data_t  res_o
);

  always_comb begin
    case (op_i)
      OP_ADD:    res_o = a_i + b_i;
      // A is the minuend
      OP_SUB:    res_o = a_i - b_i;
      // Low word of the product
      OP_MUL:    res_o = a_i * b_i;
      OP_AND:    res_o = a_i & b_i;
      OP_OR:     res_o = a_i | b_i;
      OP_XOR:    res_o = a_i ^ b_i;
      OP_PASS_A: res_o = a_i;
      default:   res_o = '0;
    endcase
  end

endmodule

//--- hw/pe.sv
// Config must stay static while beats are in flight and SRC_SELF reads back the held result
`timescale 1ns/1ns

module pe
  import pea_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  stream_t   stream_i,
  input  stream_t   north_i,
  input  stream_t   south_i,
  input  stream_t   west_i,
  input  stream_t   east_i,
  input  pe_cfg_t   cfg_i,
  input  pe_const_t const_i,
  output stream_t   res_o
);

  // One candidate beat per pe_src_e value
  stream_t [2**$bits(pe_src_e)-1:0] src_beat;
  stream_t                          opnd_a;
  stream_t                          opnd_b;
  logic                             fire;
  data_t                            alu_res;
  logic                             valid_q;
  data_t                            data_q;

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////
  always_comb begin
    src_beat[SRC_OFF]    = '{valid: 1'b0, data: '0};
    src_beat[SRC_STREAM] = stream_i;
    src_beat[SRC_CONST]  = '{valid: 1'b1, data: {{(DATA_W-CONST_W){1'b0}}, const_i}};
    src_beat[SRC_SELF]   = '{valid: 1'b1, data: data_q};
    src_beat[SRC_NORTH]  = north_i;
    src_beat[SRC_SOUTH]  = south_i;
    src_beat[SRC_WEST]   = west_i;
    src_beat[SRC_EAST]   = east_i;
  end

  assign opnd_a = src_beat[cfg_i.src_a];
  assign opnd_b = src_beat[cfg_i.src_b];

  // Fires only when both operands are present in the same cycle
  assign fire = opnd_a.valid & opnd_b.valid;

  pe_alu u_alu (
    .op_i  (cfg_i.op),
    .a_i   (opnd_a.data),
    .b_i   (opnd_b.data),
    .res_o (alu_res)
  );

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      data_q  <= '0;
    end else begin
      valid_q <= fire;
      // Held between firings, which is what accumulation relies on
      if (fire) begin
        data_q <= alu_res;
      end
    end
  end

  assign res_o = '{valid: valid_q, data: data_q};

  // A PE with an OFF operand never produces a beat
  a_off_silent: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cfg_i.src_a == SRC_OFF || cfg_i.src_b == SRC_OFF) |=> !res_o.valid
  );

endmodule

//--- hw/pe_mesh.sv
// Fixed 4x4 grid with no latency of its own. Missing neighbors read as valid zero beats
`timescale 1ns/1ns

module pe_mesh
  import pea_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  stream_t                                stream_in_i,
  input  pe_cfg_t   [PEA_ROWS-1:0][PEA_COLS-1:0] pe_cfg_i,
  input  pe_const_t [PEA_ROWS-1:0][PEA_COLS-1:0] pe_const_i,
  output stream_t   [PEA_ROWS-1:0][PEA_COLS-1:0] pe_res_o
);

  for (genvar r = 0; r < PEA_ROWS; r++) begin : g_row
    for (genvar c = 0; c < PEA_COLS; c++) begin : g_col
      stream_t strm_b;
      stream_t north_b;
      stream_t south_b;
      stream_t west_b;
      stream_t east_b;

      // Lower rows get a constant valid zero instead of the stream
      if (r < STREAM_ROWS) begin : g_strm
        assign strm_b = stream_in_i;
      end else begin : g_no_strm
        assign strm_b = EDGE_BEAT;
      end

      if (r == 0) begin : g_n_edge
        assign north_b = EDGE_BEAT;
      end else begin : g_n
        assign north_b = pe_res_o[r-1][c];
      end

      if (r == PEA_ROWS-1) begin : g_s_edge
        assign south_b = EDGE_BEAT;
      end else begin : g_s
        assign south_b = pe_res_o[r+1][c];
      end

      if (c == 0) begin : g_w_edge
        assign west_b = EDGE_BEAT;
      end else begin : g_w
        assign west_b = pe_res_o[r][c-1];
      end

      if (c == PEA_COLS-1) begin : g_e_edge
        assign east_b = EDGE_BEAT;
      end else begin : g_e
        assign east_b = pe_res_o[r][c+1];
      end

      pe u_pe (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stream_i (strm_b),
        .north_i  (north_b),
        .south_i  (south_b),
        .west_i   (west_b),
        .east_i   (east_b),
        .cfg_i    (pe_cfg_i[r][c]),
        .const_i  (pe_const_i[r][c]),
        .res_o    (pe_res_o[r][c])
      );
    end
  end

endmodule

//--- hw/pea.sv
// No back-pressure. Configuration and row selectors must stay stable while beats are in flight
`timescale 1ns/1ns

module pea
  import pea_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  stream_t                                stream_i,
  input  pe_cfg_t   [PEA_ROWS-1:0][PEA_COLS-1:0] pe_cfg_i,
  input  pe_const_t [PEA_ROWS-1:0][PEA_COLS-1:0] pe_const_i,
  input  row_sel_t  [PEA_COLS-1:0]               row_sel_i,
  output stream_t   [PEA_COLS-1:0]               stream_o
);

  stream_t                              stream_q;
  stream_t [PEA_ROWS-1:0][PEA_COLS-1:0] pe_res;
  logic    [PEA_COLS-1:0]               out_valid;

  ////////////////////////////////////////////////////////////
  // Input register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stream_q <= '0;
    end else begin
      stream_q <= stream_i;
    end
  end

  pe_mesh u_mesh (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stream_in_i (stream_q),
    .pe_cfg_i    (pe_cfg_i),
    .pe_const_i  (pe_const_i),
    .pe_res_o    (pe_res)
  );

  ////////////////////////////////////////////////////////////
  // Column outputs
  ////////////////////////////////////////////////////////////
  // Combinational row pick, adds no cycle
  always_comb begin
    for (int c = 0; c < PEA_COLS; c++) begin
      stream_o[c]  = pe_res[row_sel_i[c]][c];
      out_valid[c] = stream_o[c].valid;
    end
  end

  // Output valids come from reset registers deep in the mesh
  a_valid_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(out_valid)
  );

endmodule

//--- dv/pea_checker.sv
// Checks only the column under test, except in tests without words where every column must stay idle
`timescale 1ns/1ns

module pea_checker
  import pea_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  stream_t                dut_in_i,
  input  stream_t [PEA_COLS-1:0] dut_out_i,
  input  logic                   active_i,
  input  logic                   test_end_i,
  input  logic [8*12-1:0]        name_i,
  input  logic [1:0]             col_i,
  input  int                     n_words_i,
  input  data_t [0:3]            dexp_i,
  input  int                     depth_i,
  output int                     pass_cnt_o,
  output int                     fail_cnt_o
);

  int cyc      = 0;
  int t_first  = -1;
  int n_seen   = 0;
  int test_err = 0;
  int n_pass   = 0;
  int n_fail   = 0;

  assign pass_cnt_o = n_pass;
  assign fail_cnt_o = n_fail;

  ////////////////////////////////////////////////////////////
  // Per-beat checks
  ////////////////////////////////////////////////////////////
  task check_beat(input data_t actual);
    int due;
    due = t_first + depth_i + 1;
    if (n_seen >= n_words_i) begin
      $display("Test %s: extra beat 0x%08h on column %0d after all words", name_i, actual,
               col_i);
      test_err++;
    end else begin
      if (n_seen == 0 && t_first < 0) begin
        $display("Test %s: beat on column %0d before any input word", name_i, col_i);
        test_err++;
      end else if (n_seen == 0 && cyc != due) begin
        $display("Test %s: first beat came in cycle %0d, it was due in cycle %0d", name_i,
                 cyc, due);
        test_err++;
      end
      if (actual !== dexp_i[n_seen]) begin
        $display("Error test %s beat %0d expected 0x%08h actual 0x%08h", name_i, n_seen,
                 dexp_i[n_seen], actual);
        test_err++;
      end
    end
    n_seen++;
  endtask

  // Nothing may show up on any column while all PEs are off
  task check_silent();
    for (int c = 0; c < PEA_COLS; c++) begin
      if (dut_out_i[c].valid !== 1'b0) begin
        $display("Test %s: column %0d shows a valid beat while all PEs are off", name_i, c);
        test_err++;
      end
    end
  endtask

  task finish_test();
    if (n_seen < n_words_i) begin
      $display("Test %s: only %0d of %0d beats arrived", name_i, n_seen, n_words_i);
      test_err++;
    end
    if (test_err == 0) begin
      $display("PASS %s", name_i);
      n_pass++;
    end else begin
      $display("FAIL %s with %0d problems", name_i, test_err);
      n_fail++;
    end
    t_first  = -1;
    n_seen   = 0;
    test_err = 0;
  endtask

  // Values sampled here are the ones held during the cycle that just ended
  always @(posedge clk_i) begin
    cyc++;
    if (rst_n_i && active_i) begin
      if (dut_in_i.valid && t_first < 0) begin
        t_first = cyc;
      end
      if (n_words_i == 0) begin
        check_silent();
      end else if (dut_out_i[col_i].valid) begin
        check_beat(dut_out_i[col_i].data);
      end
    end
    if (test_end_i) begin
      finish_test();
    end
  end

endmodule

//--- include/pea_tb_vectors.svh
// Include inside a scope that imports pea_pkg. Every PE not placed by a test stays SRC_OFF
`ifndef PEA_TB_VECTORS_SVH
`define PEA_TB_VECTORS_SVH

// One configured PE, entries with used low are skipped
typedef struct packed {
  logic      used;
  logic [1:0] row;
  logic [1:0] col;
  pe_cfg_t   cfg;
  pe_const_t cval;
} tb_place_t;

// sel drives the row selector of every column
typedef struct packed {
  logic [8*12-1:0]   name;
  logic              do_reset;
  tb_place_t [0:3]   place;
  row_sel_t          sel;
  logic [1:0]        col;
  logic [2:0]        n_words;
  data_t [0:3]       din;
  data_t [0:3]       dexp;
  logic [3:0]        depth;
} tb_vec_t;

localparam tb_place_t P_NONE = '0;

function automatic tb_place_t pl(input int r, input int c, input pe_src_e a,
                                 input pe_src_e b, input pe_op_e fn, input int k);
  tb_place_t p;
  p.used = 1'b1;
  p.row  = 2'(r);
  p.col  = 2'(c);
  p.cfg  = '{src_a: a, src_b: b, op: fn};
  p.cval = pe_const_t'(k);
  return p;
endfunction

localparam int TB_N_TESTS = 13;

localparam tb_vec_t TB_VECTORS [TB_N_TESTS] = '{
  '{"reset_idle", 1'b1, '{P_NONE, P_NONE, P_NONE, P_NONE},
    2'd0, 2'd0, 3'd0, '{0, 0, 0, 0}, '{0, 0, 0, 0}, 4'd6},
  // Running sum starts from the cleared result register
  '{"accumulate", 1'b1, '{pl(0, 0, SRC_SELF, SRC_STREAM, OP_ADD, 0), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd0, 3'd4, '{1, 2, 3, 4}, '{1, 3, 6, 10}, 4'd1},
  '{"alu_add", 1'b0, '{pl(0, 0, SRC_STREAM, SRC_CONST, OP_ADD, 7), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd0, 3'd2, '{100, 5, 0, 0}, '{107, 12, 0, 0}, 4'd1},
  '{"alu_sub", 1'b0, '{pl(0, 1, SRC_STREAM, SRC_CONST, OP_SUB, 7), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd1, 3'd2, '{100, 3, 0, 0}, '{93, 32'hFFFF_FFFC, 0, 0}, 4'd1},
  '{"alu_mul", 1'b0, '{pl(0, 2, SRC_STREAM, SRC_CONST, OP_MUL, 4), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd2, 3'd2, '{1000, 32'h4000_0001, 0, 0}, '{4000, 4, 0, 0}, 4'd1},
  '{"alu_and", 1'b0, '{pl(0, 3, SRC_STREAM, SRC_CONST, OP_AND, 'h3C), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd3, 3'd1, '{32'hF0F0_F0FF, 0, 0, 0}, '{32'h3C, 0, 0, 0}, 4'd1},
  '{"alu_or", 1'b0, '{pl(0, 0, SRC_STREAM, SRC_CONST, OP_OR, 'hAB), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd0, 3'd1, '{32'h1234_5600, 0, 0, 0}, '{32'h1234_56AB, 0, 0, 0}, 4'd1},
  '{"alu_xor", 1'b0, '{pl(0, 1, SRC_STREAM, SRC_CONST, OP_XOR, 'h0F), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd1, 3'd1, '{32'hFFFF_FFFF, 0, 0, 0}, '{32'hFFFF_FFF0, 0, 0, 0}, 4'd1},
  '{"alu_pass_a", 1'b0,
    '{pl(0, 2, SRC_STREAM, SRC_CONST, OP_PASS_A, 'h55), P_NONE, P_NONE, P_NONE},
    2'd0, 2'd2, 3'd1, '{32'hDEAD_BEEF, 0, 0, 0}, '{32'hDEAD_BEEF, 0, 0, 0}, 4'd1},
  // Two beats in flight down column 2
  '{"vert_chain", 1'b0,
    '{pl(0, 2, SRC_STREAM, SRC_CONST, OP_ADD, 3),
      pl(1, 2, SRC_NORTH, SRC_CONST, OP_MUL, 5),
      pl(2, 2, SRC_NORTH, SRC_NORTH, OP_PASS_A, 0),
      pl(3, 2, SRC_NORTH, SRC_NORTH, OP_PASS_A, 0)},
    2'd3, 2'd2, 3'd2, '{10, 20, 0, 0}, '{65, 115, 0, 0}, 4'd4},
  '{"horiz_row1", 1'b0,
    '{pl(1, 0, SRC_STREAM, SRC_STREAM, OP_PASS_A, 0),
      pl(1, 1, SRC_WEST, SRC_WEST, OP_PASS_A, 0),
      pl(1, 2, SRC_WEST, SRC_WEST, OP_PASS_A, 0), P_NONE},
    2'd1, 2'd2, 3'd2, '{32'hCAFE_0001, 32'hCAFE_0002, 0, 0},
    '{32'hCAFE_0001, 32'hCAFE_0002, 0, 0}, 4'd3},
  '{"horiz_east", 1'b0,
    '{pl(0, 3, SRC_STREAM, SRC_STREAM, OP_PASS_A, 0),
      pl(0, 2, SRC_EAST, SRC_EAST, OP_PASS_A, 0), P_NONE, P_NONE},
    2'd0, 2'd2, 3'd1, '{32'h0BAD_F00D, 0, 0, 0}, '{32'h0BAD_F00D, 0, 0, 0}, 4'd2},
  // Both branches take one extra hop so the operands meet at PE(1,1)
  '{"join_add", 1'b0,
    '{pl(0, 0, SRC_STREAM, SRC_STREAM, OP_PASS_A, 0),
      pl(0, 1, SRC_WEST, SRC_WEST, OP_PASS_A, 0),
      pl(1, 0, SRC_NORTH, SRC_NORTH, OP_PASS_A, 0),
      pl(1, 1, SRC_NORTH, SRC_WEST, OP_ADD, 0)},
    2'd1, 2'd1, 3'd2, '{21, 32'h8000_0001, 0, 0}, '{42, 2, 0, 0}, 4'd3}
};

`endif

//--- dv/pea_tb.sv
// Runs the vector table in order. Inputs change a fixed delay after the rising edge
`timescale 1ns/1ns

module pea_tb
  import pea_pkg::*;
;

  `include "pea_tb_vectors.svh"

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DLY    = 10;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES  = 6;

  logic                                   clk = 1'b0;
  logic                                   rst_n;
  stream_t                                stream;
  pe_cfg_t   [PEA_ROWS-1:0][PEA_COLS-1:0] pe_cfg;
  pe_const_t [PEA_ROWS-1:0][PEA_COLS-1:0] pe_const;
  row_sel_t  [PEA_COLS-1:0]               row_sel;
  stream_t   [PEA_COLS-1:0]               stream_out;

  logic            active;
  logic            test_end;
  logic [8*12-1:0] cur_name;
  logic [1:0]      cur_col;
  int              cur_n_words;
  data_t [0:3]     cur_dexp;
  int              cur_depth;
  int              pass_cnt;
  int              fail_cnt;

  always #(CLK_PERIOD/2) clk = ~clk;

  pea dut_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .stream_i   (stream),
    .pe_cfg_i   (pe_cfg),
    .pe_const_i (pe_const),
    .row_sel_i  (row_sel),
    .stream_o   (stream_out)
  );

  pea_checker chk_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .dut_in_i   (stream),
    .dut_out_i  (stream_out),
    .active_i   (active),
    .test_end_i (test_end),
    .name_i     (cur_name),
    .col_i      (cur_col),
    .n_words_i  (cur_n_words),
    .dexp_i     (cur_dexp),
    .depth_i    (cur_depth),
    .pass_cnt_o (pass_cnt),
    .fail_cnt_o (fail_cnt)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic pulse_reset();
    rst_n = 1'b0;
    wait_cycles(RESET_CYCLES);
    rst_n = 1'b1;
  endtask

  // Unplaced PEs fall back to SRC_OFF
  task automatic load_config(input tb_vec_t v);
    pe_cfg   = '0;
    pe_const = '0;
    for (int p = 0; p < 4; p++) begin
      if (v.place[p].used) begin
        pe_cfg[v.place[p].row][v.place[p].col]   = v.place[p].cfg;
        pe_const[v.place[p].row][v.place[p].col] = v.place[p].cval;
      end
    end
    for (int c = 0; c < PEA_COLS; c++) begin
      row_sel[c] = v.sel;
    end
  endtask

  task automatic send_words(input tb_vec_t v);
    for (int i = 0; i < int'(v.n_words); i++) begin
      stream = '{valid: 1'b1, data: v.din[i]};
      wait_cycles(1);
    end
    stream = '0;
  endtask

  task automatic run_test(input tb_vec_t v);
    cur_name    = v.name;
    cur_col     = v.col;
    cur_n_words = int'(v.n_words);
    cur_dexp    = v.dexp;
    cur_depth   = int'(v.depth);
    load_config(v);
    if (v.do_reset) begin
      pulse_reset();
    end
    active = 1'b1;
    wait_cycles(IDLE_CYCLES);
    send_words(v);
    // Drain the chain, the last of these cycles closes the test
    wait_cycles(cur_depth + 3);
    test_end = 1'b1;
    wait_cycles(1);
    test_end = 1'b0;
    active   = 1'b0;
  endtask

  function automatic int run_budget();
    int cycles;
    cycles = RESET_CYCLES;
    for (int i = 0; i < TB_N_TESTS; i++) begin
      cycles += int'(TB_VECTORS[i].depth) + 14;
      if (TB_VECTORS[i].do_reset) begin
        cycles += RESET_CYCLES;
      end
    end
    return 2 * cycles;
  endfunction

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    rst_n       = 1'b0;
    stream      = '0;
    pe_cfg      = '0;
    pe_const    = '0;
    row_sel     = '0;
    active      = 1'b0;
    test_end    = 1'b0;
    cur_name    = '0;
    cur_col     = '0;
    cur_n_words = 0;
    cur_dexp    = '0;
    cur_depth   = 0;
    wait_cycles(RESET_CYCLES);
    rst_n = 1'b1;
    for (int i = 0; i < TB_N_TESTS; i++) begin
      run_test(TB_VECTORS[i]);
    end
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == TB_N_TESTS) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = run_budget();
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- cgra_pea.f
+incdir+include
hw/pea_pkg.sv
hw/pe_alu.sv
hw/pe.sv
hw/pe_mesh.sv
hw/pea.sv
dv/pea_checker.sv
dv/pea_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the PE array testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f cgra_pea.f --top-module pea_tb

out="$(./obj_dir/Vpea_tb)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Testbench passed'; then
  echo "Simulation result: PASS"
  exit 0
fi

echo "Simulation result: FAIL"
exit 1
